//--- Makefile
# Verilator flow for the instruction fetch front end.
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module fetch_top

sim:
	verilator --binary --timing -f sources.f --top-module tb_fetch_top \
		--Mdir $(OBJ) -o sim_fetch
	./$(OBJ)/sim_fetch | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- include/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First PC after reset.
`define FETCH_RESET_PC 32'h0000_0000

// ROM depth in 32-bit words.
`define ROM_WORDS 1024

// Fetch is not permitted at or above this byte address.
`define EXEC_LIMIT 2048

`define ROM_LATENCY 3 // Address handshake to rvalid.

// Initial and maximum packet credits toward decode.
`define FETCH_CREDITS 4

`endif

//--- source/axi_fetch_master.sv
`timescale 1ns/1ns

module axi_fetch_master (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  fetch_pkg::addr_t  req_pc,
    output logic              resp_valid,
    output fetch_pkg::inst_t  resp_inst,
    output logic              resp_err,
    output logic              arvalid,
    output fetch_pkg::addr_t  araddr,
    input  logic              arready,
    input  logic              rvalid,
    output logic              rready,
    input  fetch_pkg::inst_t  rdata,
    input  fetch_pkg::resp_t  rresp
);
    import fetch_pkg::*;

    logic ar_fire;
    logic r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // Address phase, then data phase.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (req_valid) begin
                arvalid <= 1'b1;
            end else if (ar_fire) begin
                arvalid <= 1'b0;
                rready  <= 1'b1; // Ready for data from the next cycle.
            end
            if (r_fire) begin
                rready     <= 1'b0;
                resp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            araddr <= req_pc;
        end
    end

    // Captured read data.
    always_ff @(posedge clk) begin
        if (r_fire) begin
            resp_inst <= rdata;
            resp_err  <= (rresp != RESP_OKAY);
        end
    end

endmodule

//--- source/fetch_ctrl.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect_valid,
    input  fetch_pkg::addr_t   redirect_pc,
    input  logic               credit_return,
    output logic               pkt_valid,
    output fetch_pkg::addr_t   pkt_pc,
    output fetch_pkg::inst_t   pkt_inst,
    output logic               pkt_fault,
    output fetch_pkg::cause_t  pkt_cause,
    output logic               req_valid,
    output fetch_pkg::addr_t   req_pc,
    input  logic               chk_done,
    input  logic               chk_fault,
    input  fetch_pkg::cause_t  chk_cause,
    input  logic               resp_valid,
    input  fetch_pkg::inst_t   resp_inst,
    input  logic               resp_err
);
    import fetch_pkg::*;

    fetch_state_t state;
    addr_t        pc;
    credit_t      credits;
    credit_t      credits_free;
    logic         squash;
    logic         chk_fault_q;
    cause_t       chk_cause_q;
    logic         issue;
    logic         emit;
    logic         pkt_bad;

    // A packet on the wire has already spent its credit.
    assign credits_free = credits - credit_t'(pkt_valid);
    assign issue = (state == FETCH_IDLE) && !redirect_valid && (credits_free != '0);
    assign emit  = (state == FETCH_WAIT) && resp_valid && !squash && !redirect_valid;
    assign pkt_bad = chk_fault_q || resp_err;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= credit_t'(`FETCH_CREDITS);
        end else begin
            credits <= credits - credit_t'(pkt_valid) + credit_t'(credit_return);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= FETCH_IDLE;
            pc          <= `FETCH_RESET_PC;
            squash      <= 1'b0;
            req_valid   <= 1'b0;
            pkt_valid   <= 1'b0;
            chk_fault_q <= 1'b0;
        end else begin
            req_valid <= issue;
            pkt_valid <= emit;
            if (chk_done) begin
                chk_fault_q <= chk_fault;
            end
            if (redirect_valid) begin
                pc <= redirect_pc;
                if ((state == FETCH_WAIT) && !resp_valid) begin
                    squash <= 1'b1; // Bus read still out, drop it on return.
                end else begin
                    squash <= 1'b0;
                    state  <= FETCH_IDLE;
                end
            end else begin
                case (state)
                    FETCH_IDLE: begin
                        if (issue) begin
                            state <= FETCH_WAIT;
                        end
                    end
                    FETCH_WAIT: begin
                        if (resp_valid) begin
                            squash <= 1'b0;
                            if (squash) begin
                                state <= FETCH_IDLE;
                            end else if (pkt_bad) begin
                                state <= FETCH_HALT;
                            end else begin
                                pc    <= pc + 32'd4;
                                state <= FETCH_IDLE;
                            end
                        end
                    end
                    FETCH_HALT: begin
                        state <= FETCH_HALT; // Only a redirect leaves.
                    end
                    default: state <= FETCH_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= pc;
        end
        if (chk_done) begin
            chk_cause_q <= chk_cause;
        end
        if (emit) begin
            pkt_pc    <= pc;
            pkt_inst  <= resp_inst;
            pkt_fault <= pkt_bad;
            pkt_cause <= chk_fault_q ? chk_cause_q : CAUSE_ACCESS_FAULT;
        end
    end

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;  // Byte address.
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  cause_t; // RISC-V exception cause.
    typedef logic [2:0]  credit_t;

    // AXI response codes.
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // Fetch exception causes.
    localparam cause_t CAUSE_MISALIGNED   = 4'd0;
    localparam cause_t CAUSE_ACCESS_FAULT = 4'd1;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_HALT
    } fetch_state_t;

endpackage

//--- source/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect_valid,
    input  fetch_pkg::addr_t   redirect_pc,
    input  logic               credit_return,
    output logic               pkt_valid,
    output fetch_pkg::addr_t   pkt_pc,
    output fetch_pkg::inst_t   pkt_inst,
    output logic               pkt_fault,
    output fetch_pkg::cause_t  pkt_cause,
    input  logic               load_en,
    input  fetch_pkg::addr_t   load_addr,
    input  fetch_pkg::inst_t   load_data
);
    import fetch_pkg::*;

    // Request and results.
    logic   req_valid;
    addr_t  req_pc;
    logic   chk_done;
    logic   chk_fault;
    cause_t chk_cause;
    logic   resp_valid;
    inst_t  resp_inst;
    logic   resp_err;

    // AXI read channels.
    logic   arvalid;
    logic   arready;
    addr_t  araddr;
    logic   rvalid;
    logic   rready;
    inst_t  rdata;
    resp_t  rresp;

    fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .credit_return  (credit_return),
        .pkt_valid      (pkt_valid),
        .pkt_pc         (pkt_pc),
        .pkt_inst       (pkt_inst),
        .pkt_fault      (pkt_fault),
        .pkt_cause      (pkt_cause),
        .req_valid      (req_valid),
        .req_pc         (req_pc),
        .chk_done       (chk_done),
        .chk_fault      (chk_fault),
        .chk_cause      (chk_cause),
        .resp_valid     (resp_valid),
        .resp_inst      (resp_inst),
        .resp_err       (resp_err)
    );

    axi_fetch_master u_axi_fetch_master (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_pc     (req_pc),
        .resp_valid (resp_valid),
        .resp_inst  (resp_inst),
        .resp_err   (resp_err),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp)
    );

    pma_check u_pma_check (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_pc    (req_pc),
        .chk_done  (chk_done),
        .chk_fault (chk_fault),
        .chk_cause (chk_cause)
    );

    inst_rom u_inst_rom (
        .clk       (clk),
        .rst       (rst),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

//--- source/inst_rom.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module inst_rom (
    input  logic              clk,
    input  logic              rst,
    input  logic              arvalid,
    input  fetch_pkg::addr_t  araddr,
    output logic              arready,
    output logic              rvalid,
    input  logic              rready,
    output fetch_pkg::inst_t  rdata,
    output fetch_pkg::resp_t  rresp,
    input  logic              load_en,
    input  fetch_pkg::addr_t  load_addr,
    input  fetch_pkg::inst_t  load_data
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`ROM_WORDS);
    localparam int CNT_W = $clog2(`ROM_LATENCY + 1);

    inst_t            mem [`ROM_WORDS];
    logic             busy;
    logic [CNT_W-1:0] lat_cnt;
    addr_t            rd_addr;
    logic             ar_fire;
    logic             data_due;
    logic             in_range;

    assign arready  = !busy;
    assign ar_fire  = arvalid && arready;
    assign in_range = (rd_addr < addr_t'(4 * `ROM_WORDS));

    // Latency expires this cycle.
    assign data_due = (ar_fire && (`ROM_LATENCY == 1))
                   || (busy && !rvalid && (lat_cnt == CNT_W'(1)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            rvalid  <= 1'b0;
            lat_cnt <= '0;
        end else begin
            if (ar_fire) begin
                busy    <= 1'b1;
                lat_cnt <= CNT_W'(`ROM_LATENCY - 1);
            end else if (busy && !rvalid) begin
                lat_cnt <= lat_cnt - CNT_W'(1);
            end
            if (data_due) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
        end
    end

    // Read data uses the latched address, or araddr for single-cycle latency.
    always_ff @(posedge clk) begin
        if (data_due) begin
            if ((`ROM_LATENCY == 1) ? (araddr < addr_t'(4 * `ROM_WORDS)) : in_range) begin
                rdata <= mem[(`ROM_LATENCY == 1) ? araddr[IDX_W+1:2] : rd_addr[IDX_W+1:2]];
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_DECERR;
            end
        end
    end

    // Preload port.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[IDX_W-1:0]] <= load_data;
        end
    end

endmodule

//--- source/pma_check.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module pma_check (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  fetch_pkg::addr_t   req_pc,
    output logic               chk_done,
    output logic               chk_fault,
    output fetch_pkg::cause_t  chk_cause
);
    import fetch_pkg::*;

    logic misaligned;
    logic not_exec;

    assign misaligned = (req_pc[1:0] != 2'b00);
    assign not_exec   = (req_pc >= addr_t'(`EXEC_LIMIT));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chk_done  <= 1'b0;
            chk_fault <= 1'b0;
            chk_cause <= CAUSE_MISALIGNED;
        end else begin
            chk_done <= req_valid;
            if (req_valid) begin
                chk_fault <= misaligned || not_exec;
                chk_cause <= misaligned ? CAUSE_MISALIGNED : CAUSE_ACCESS_FAULT; // Alignment first.
            end
        end
    end

endmodule

//--- sources.f
+incdir+include
source/fetch_pkg.sv
source/axi_fetch_master.sv
source/pma_check.sv
source/fetch_ctrl.sv
source/inst_rom.sv
source/fetch_top.sv
verif/tb_fetch_top.sv

//--- verif/tb_fetch_top.sv
`timescale 1ns/1ns
`include "fetch_config.svh"

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int IDX_W         = $clog2(`ROM_WORDS);
    localparam int SEQ_PKTS      = 40;
    localparam int CREDIT_PKTS   = 60;
    localparam int REDIRECT_PKTS = 80;
    localparam int FAULT_PKTS    = 13; // Fault packets and the fetch that resumes after them.
    localparam int CYCLE_LIMIT   = 200 * (SEQ_PKTS + CREDIT_PKTS + REDIRECT_PKTS + FAULT_PKTS);

    localparam int CREDIT_PROMPT = 0;
    localparam int CREDIT_RANDOM = 1;
    localparam int CREDIT_HOLD   = 2;

    logic   clk;
    logic   rst;
    logic   redirect_valid;
    addr_t  redirect_pc;
    logic   credit_return = 1'b0;
    logic   pkt_valid;
    addr_t  pkt_pc;
    inst_t  pkt_inst;
    logic   pkt_fault;
    cause_t pkt_cause;
    logic   load_en;
    addr_t  load_addr;
    inst_t  load_data;

    // Reference model.
    inst_t rom_model [`ROM_WORDS];
    addr_t exp_pc      = `FETCH_RESET_PC;
    logic  halted      = 1'b0;
    int    outstanding = 0; // Packets sent minus credits returned.
    int    pkt_count   = 0;
    int    cycle_count = 0;
    int    error_count = 0;
    int    credit_mode = CREDIT_PROMPT;
    int    hold_left   = 0;

    fetch_top DUT (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .credit_return  (credit_return),
        .pkt_valid      (pkt_valid),
        .pkt_pc         (pkt_pc),
        .pkt_inst       (pkt_inst),
        .pkt_fault      (pkt_fault),
        .pkt_cause      (pkt_cause),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure();
        error_count++;
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // One packet against the expected path.
    task automatic check_packet();
        logic misaligned;
        logic no_exec;
        if (halted) begin
            $display("Error at %0t ns: a packet arrived while fetch was halted.", $time);
            stop_with_failure();
        end
        pkt_count++;
        outstanding++;
        if (outstanding > `FETCH_CREDITS) begin
            $display("Error at %0t ns: more packets in flight than credits.", $time);
            stop_with_failure();
        end
        check_value("pkt_pc", pkt_pc, exp_pc);
        misaligned = (exp_pc[1:0] != 2'b00);
        no_exec    = (exp_pc >= `EXEC_LIMIT);
        if (misaligned || no_exec) begin
            check_value("pkt_fault", 32'(pkt_fault), 32'd1);
            check_value("pkt_cause", 32'(pkt_cause), misaligned ? 32'd0 : 32'd1);
            halted = 1'b1;
        end else begin
            check_value("pkt_fault", 32'(pkt_fault), 32'd0);
            check_value("pkt_inst", pkt_inst, rom_model[exp_pc[IDX_W+1:2]]);
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    // Monitor samples at the falling edge.
    always @(negedge clk) begin
        if (!rst) begin
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
                stop_with_failure();
            end
            if (pkt_valid) begin
                check_packet(); // Still the old path in a redirect cycle.
            end
            if (credit_return) begin
                outstanding--;
            end
            if (redirect_valid) begin
                exp_pc = redirect_pc;
                halted = 1'b0;
            end
        end
    end

    // Decode side credit returns.
    always @(posedge clk) begin
        if (rst || credit_mode == CREDIT_HOLD) begin
            credit_return <= 1'b0;
        end else if (credit_mode == CREDIT_PROMPT) begin
            credit_return <= (outstanding > 0);
        end else if (hold_left > 0) begin
            hold_left--;
            credit_return <= 1'b0;
        end else if ($urandom_range(0, 39) == 0) begin
            hold_left = $urandom_range(20, 60);
            credit_return <= 1'b0;
        end else begin
            credit_return <= (outstanding > 0) && ($urandom_range(0, 2) == 0);
        end
    end

    task automatic set_credit_mode(input int mode);
        @(negedge clk);
        credit_mode = mode;
    endtask

    task automatic send_redirect(input addr_t target);
        @(posedge clk);
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
        @(posedge clk);
        redirect_valid <= 1'b0;
    endtask

    task automatic wait_packets(input int n);
        int target;
        target = pkt_count + n;
        while (pkt_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_credits_exhausted();
        while (outstanding < `FETCH_CREDITS) begin
            @(posedge clk);
        end
    endtask

    // Aligned code PC with room for a run of packets below the limit.
    function automatic addr_t random_code_pc(input int run);
        return addr_t'(4 * $urandom_range(0, `EXEC_LIMIT / 4 - run));
    endfunction

    initial begin
        int    i;
        int    held_count;
        int    target;
        inst_t word;
        void'($urandom(58));
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;

        // ROM preload while in reset.
        for (i = 0; i < `ROM_WORDS; i++) begin
            word = $urandom;
            rom_model[i[IDX_W-1:0]] = word;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr_t'(i);
            load_data <= word;
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Sequential fetch from the reset PC.
        wait_packets(SEQ_PKTS);

        // Starve fetch of credits, then random returns.
        set_credit_mode(CREDIT_HOLD);
        wait_credits_exhausted();
        held_count = pkt_count;
        repeat (40) @(posedge clk);
        check_value("pkt_count", 32'(pkt_count), 32'(held_count));
        set_credit_mode(CREDIT_RANDOM);
        wait_packets(CREDIT_PKTS);

        // Random redirects under random credit flow.
        target = pkt_count + REDIRECT_PKTS;
        while (pkt_count < target) begin
            repeat ($urandom_range(0, 30)) @(posedge clk);
            send_redirect(random_code_pc(1));
        end

        // Misaligned target halts until the next redirect.
        set_credit_mode(CREDIT_PROMPT);
        send_redirect(random_code_pc(1) | addr_t'($urandom_range(1, 3)));
        wait_packets(1);
        repeat (40) @(posedge clk);
        send_redirect(random_code_pc(5));
        wait_packets(5);

        // Data half of the ROM, then past the ROM.
        send_redirect(addr_t'(`EXEC_LIMIT
            + 4 * $urandom_range(0, (4 * `ROM_WORDS - `EXEC_LIMIT) / 4 - 1)));
        wait_packets(1);
        repeat (20) @(posedge clk);
        send_redirect(addr_t'(4 * `ROM_WORDS + 4 * $urandom_range(0, 1023)));
        wait_packets(1);
        repeat (20) @(posedge clk);
        send_redirect(random_code_pc(5));
        wait_packets(5);
        repeat (10) @(posedge clk);

        if (error_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule
